// ==== client/client_fsm.sv ====
`timescale 1ns/10ps

module client_fsm #(
    parameter int RAM_DEPTH = 64,
    parameter int ADDRW     = $clog2(RAM_DEPTH),
    parameter int CNTW      = $clog2(RAM_DEPTH + 1)
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 processor_enable,

    output logic                 waddr_en,
    output loader_pkg::axi_addr_t waddr,
    output logic                 wdata_en,
    output loader_pkg::axi_strb_t wstrb,
    output loader_pkg::axi_data_t wdata,
    input  logic                 w_success,

    output logic                 raddr_en,
    output loader_pkg::axi_addr_t raddr,
    input  loader_pkg::axi_data_t rdata,
    input  logic                 r_success,

    output logic                 ram_we,
    output logic [ADDRW-1:0]     ram_addr,
    output loader_pkg::byte_t    ram_wdata,

    output logic                 exec_req,
    output loader_pkg::byte_t    seed,
    output logic [CNTW-1:0]      count,
    input  logic                 exec_ack,
    input  loader_pkg::byte_t    result
);

    typedef enum logic [3:0] {
        INIT,
        PROGRAM_RECEIVE_START,
        PROGRAM_BYTES_COUNT,
        PROGRAM_RECEIVE,
        DATA_RECEIVE_START,
        DATA_RECEIVE,
        EXEC_START,
        EXEC,
        RESULT_SEND
    } state_t;

    state_t            state, n_state;
    logic              pending;     // A bus transfer is in flight
    logic              is_wr, is_rd;
    logic [CNTW-1:0]   byte_cnt;
    loader_pkg::byte_t rx_byte;
    loader_pkg::byte_t result_q;

    assign rx_byte = rdata[7:0];

    assign is_wr = (state == PROGRAM_RECEIVE_START) || (state == DATA_RECEIVE_START) ||
                   (state == RESULT_SEND);
    assign is_rd = (state == PROGRAM_BYTES_COUNT) || (state == PROGRAM_RECEIVE) ||
                   (state == DATA_RECEIVE);

    // Each request pulses once, on the first cycle of its state
    assign waddr_en = is_wr && !pending;
    assign wdata_en = is_wr && !pending;
    assign raddr_en = is_rd && !pending;
    assign waddr    = loader_pkg::UART_ADDR;
    assign raddr    = loader_pkg::UART_ADDR;
    assign wstrb    = loader_pkg::axi_strb_t'(1);

    always_comb begin
        case (state)
            PROGRAM_RECEIVE_START: wdata = loader_pkg::axi_data_t'(loader_pkg::CMD_PROGRAM);
            DATA_RECEIVE_START:    wdata = loader_pkg::axi_data_t'(loader_pkg::CMD_DATA);
            default:               wdata = loader_pkg::axi_data_t'(result_q);
        endcase
    end

    assign ram_we    = (state == PROGRAM_RECEIVE) && r_success;
    assign ram_addr  = byte_cnt[ADDRW-1:0];
    assign ram_wdata = rx_byte;

    assign exec_req         = (state == EXEC);
    assign processor_enable = (state == EXEC_START) || (state == EXEC);

    always_comb begin
        n_state = state;
        case (state)
            INIT: n_state = PROGRAM_RECEIVE_START;
            PROGRAM_RECEIVE_START: begin
                if (w_success) n_state = PROGRAM_BYTES_COUNT;
            end
            PROGRAM_BYTES_COUNT: begin
                if (r_success) begin
                    n_state = (rx_byte == 8'd0) ? DATA_RECEIVE_START : PROGRAM_RECEIVE;
                end
            end
            PROGRAM_RECEIVE: begin
                if (r_success && (byte_cnt + 1'b1 == count)) n_state = DATA_RECEIVE_START;
            end
            DATA_RECEIVE_START: begin
                if (w_success) n_state = DATA_RECEIVE;
            end
            DATA_RECEIVE: begin
                if (r_success) n_state = EXEC_START;
            end
            EXEC_START: begin
                if (!exec_ack) n_state = EXEC;  // Core has released the last handshake
            end
            EXEC: begin
                if (exec_ack) n_state = RESULT_SEND;
            end
            RESULT_SEND: begin
                if (w_success) n_state = PROGRAM_RECEIVE_START;
            end
            default: n_state = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= INIT;
            pending  <= 1'b0;
            count    <= '0;
            byte_cnt <= '0;
        end else begin
            state <= n_state;
            if (w_success || r_success) begin
                pending <= 1'b0;
            end else if (waddr_en || raddr_en) begin
                pending <= 1'b1;
            end
            if (state == PROGRAM_BYTES_COUNT && r_success) begin
                byte_cnt <= '0;
                if (rx_byte > RAM_DEPTH) begin
                    count <= CNTW'(RAM_DEPTH);  // Longer programs are clipped
                end else begin
                    count <= CNTW'(rx_byte);
                end
            end
            if (ram_we) byte_cnt <= byte_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA_RECEIVE && r_success) seed <= rx_byte;
        if (state == EXEC && exec_ack) result_q <= result;
    end

endmodule

// ==== common/loader_pkg.sv ====
package loader_pkg;

    localparam int AXI_ADDRW = 16;
    localparam int AXI_DATAW = 32;

    typedef logic [AXI_ADDRW-1:0]   axi_addr_t;
    typedef logic [AXI_DATAW-1:0]   axi_data_t;
    typedef logic [AXI_DATAW/8-1:0] axi_strb_t;
    typedef logic [7:0]             byte_t;

    // Data register of the UART, the only register on the bus
    localparam axi_addr_t UART_ADDR = 16'h0010;

    // Prompt bytes sent to the host
    localparam byte_t CMD_PROGRAM = 8'h99;
    localparam byte_t CMD_DATA    = 8'hAA;

    // Opcodes in bits 7:6 of an instruction
    localparam logic [1:0] OP_ADD = 2'd0;
    localparam logic [1:0] OP_XOR = 2'd1;
    localparam logic [1:0] OP_SUB = 2'd2;
    localparam logic [1:0] OP_ROL = 2'd3;

endpackage

// ==== filelist.f ====
common/loader_pkg.sv
source/program_ram.sv
source/accum_core.sv
source/uart_regs.sv
source/axi_lite_master.sv
client/client_fsm.sv
source/loader_top.sv
verif/tb_loader_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_loader_top -f filelist.f \
    -o tb_loader_top > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_loader_top > sim.log 2>&1
cat sim.log
grep -q "Done: no errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== source/accum_core.sv ====
`timescale 1ns/10ps

module accum_core #(
    parameter int RAM_DEPTH = 64,
    parameter int ADDRW     = $clog2(RAM_DEPTH),
    parameter int CNTW      = $clog2(RAM_DEPTH + 1)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              exec_req,
    input  loader_pkg::byte_t seed,
    input  logic [CNTW-1:0]   count,
    output logic              exec_ack,
    output loader_pkg::byte_t result,
    output logic [ADDRW-1:0]  core_raddr,
    input  loader_pkg::byte_t ram_rdata
);

    typedef enum logic [1:0] {IDLE, FETCH, EXECUTE, DONE} state_t;

    state_t            state;
    logic [CNTW-1:0]   pc;
    loader_pkg::byte_t acc, imm, alu;
    logic [15:0]       rot_wide;

    assign core_raddr = pc[ADDRW-1:0];
    assign exec_ack   = (state == DONE);
    assign result     = acc;

    assign imm      = {2'b00, ram_rdata[5:0]};
    assign rot_wide = {acc, acc} << ram_rdata[2:0];

    always_comb begin
        case (ram_rdata[7:6])
            loader_pkg::OP_ADD: alu = acc + imm;
            loader_pkg::OP_XOR: alu = acc ^ imm;
            loader_pkg::OP_SUB: alu = acc - imm;
            default:            alu = rot_wide[15:8];  // Rotate left by bits 2:0
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    pc <= '0;
                    if (exec_req) state <= (count == '0) ? DONE : FETCH;
                end
                FETCH: state <= EXECUTE;    // RAM answers in the next cycle
                EXECUTE: begin
                    pc    <= pc + 1'b1;
                    state <= (pc + 1'b1 == count) ? DONE : FETCH;
                end
                DONE: begin
                    if (!exec_req) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && exec_req) acc <= seed;
        else if (state == EXECUTE) acc <= alu;
    end

endmodule

// ==== source/axi_lite_master.sv ====
`timescale 1ns/10ps

module axi_lite_master (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  waddr_en,
    input  loader_pkg::axi_addr_t waddr,
    input  logic                  wdata_en,
    input  loader_pkg::axi_strb_t wstrb,
    input  loader_pkg::axi_data_t wdata,
    input  logic                  raddr_en,
    input  loader_pkg::axi_addr_t raddr,
    output logic                  w_success,
    output logic                  r_success,
    output loader_pkg::axi_data_t rdata,

    output logic                  awvalid,
    output loader_pkg::axi_addr_t awaddr,
    input  logic                  awready,
    output logic                  wvalid,
    output loader_pkg::axi_data_t wdata_o,
    output loader_pkg::axi_strb_t wstrb_o,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    output logic                  arvalid,
    output loader_pkg::axi_addr_t araddr,
    input  logic                  arready,
    input  logic                  rvalid,
    input  loader_pkg::axi_data_t rdata_i,
    output logic                  rready
);

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            w_success <= 1'b0;
            r_success <= 1'b0;
        end else begin
            // Address and data channels are released independently
            if (waddr_en) awvalid <= 1'b1;
            else if (awready) awvalid <= 1'b0;
            if (wdata_en) wvalid <= 1'b1;
            else if (wready) wvalid <= 1'b0;
            if (waddr_en) bready <= 1'b1;
            else if (bvalid) bready <= 1'b0;
            w_success <= bvalid && bready;

            if (raddr_en) arvalid <= 1'b1;
            else if (arready) arvalid <= 1'b0;
            if (raddr_en) rready <= 1'b1;
            else if (rvalid) rready <= 1'b0;
            r_success <= rvalid && rready;
        end
    end

    always_ff @(posedge clk) begin
        if (waddr_en) awaddr <= waddr;
        if (wdata_en) begin
            wdata_o <= wdata;
            wstrb_o <= wstrb;
        end
        if (raddr_en) araddr <= raddr;
        if (rvalid && rready) rdata <= rdata_i;
    end

endmodule

// ==== source/loader_top.sv ====
`timescale 1ns/10ps

module loader_top #(
    parameter int RAM_DEPTH = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_req,
    input  loader_pkg::byte_t rx_data,
    output logic              rx_ack,
    output logic              tx_req,
    output loader_pkg::byte_t tx_data,
    input  logic              tx_ack,
    output logic              busy
);

    localparam int ADDRW = $clog2(RAM_DEPTH);
    localparam int CNTW  = $clog2(RAM_DEPTH + 1);

    logic                  waddr_en, wdata_en, w_success, raddr_en, r_success;
    loader_pkg::axi_addr_t waddr, raddr, awaddr, araddr;
    loader_pkg::axi_strb_t wstrb, m_wstrb;
    loader_pkg::axi_data_t wdata, rdata, m_wdata, m_rdata;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    logic                  ram_we;
    logic [ADDRW-1:0]      ram_addr, core_raddr;
    loader_pkg::byte_t     ram_wdata, ram_rdata, seed, result;
    logic                  exec_req, exec_ack;
    logic [CNTW-1:0]       count;

    client_fsm #(.RAM_DEPTH(RAM_DEPTH)) i_client (
        .clk(clk), .rst(rst), .processor_enable(busy),
        .waddr_en(waddr_en), .waddr(waddr), .wdata_en(wdata_en), .wstrb(wstrb),
        .wdata(wdata), .w_success(w_success),
        .raddr_en(raddr_en), .raddr(raddr), .rdata(rdata), .r_success(r_success),
        .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .exec_req(exec_req), .seed(seed), .count(count),
        .exec_ack(exec_ack), .result(result)
    );

    axi_lite_master i_master (
        .clk(clk), .rst(rst),
        .waddr_en(waddr_en), .waddr(waddr), .wdata_en(wdata_en), .wstrb(wstrb),
        .wdata(wdata), .raddr_en(raddr_en), .raddr(raddr),
        .w_success(w_success), .r_success(r_success), .rdata(rdata),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata_o(m_wdata), .wstrb_o(m_wstrb), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata_i(m_rdata), .rready(rready)
    );

    uart_regs i_uart (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(m_wdata), .wstrb(m_wstrb), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(m_rdata), .rready(rready),
        .rx_req(rx_req), .rx_data(rx_data), .rx_ack(rx_ack),
        .tx_req(tx_req), .tx_data(tx_data), .tx_ack(tx_ack)
    );

    program_ram #(.RAM_DEPTH(RAM_DEPTH)) i_ram (
        .clk(clk), .we(ram_we), .waddr(ram_addr), .wdata(ram_wdata),
        .raddr(core_raddr), .rdata(ram_rdata)
    );

    accum_core #(.RAM_DEPTH(RAM_DEPTH)) i_core (
        .clk(clk), .rst(rst), .exec_req(exec_req), .seed(seed), .count(count),
        .exec_ack(exec_ack), .result(result),
        .core_raddr(core_raddr), .ram_rdata(ram_rdata)
    );

endmodule

// ==== source/program_ram.sv ====
`timescale 1ns/10ps

module program_ram #(
    parameter int RAM_DEPTH = 64,
    parameter int ADDRW     = $clog2(RAM_DEPTH)
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDRW-1:0]  waddr,
    input  loader_pkg::byte_t wdata,
    input  logic [ADDRW-1:0]  raddr,
    output loader_pkg::byte_t rdata
);

    loader_pkg::byte_t mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
        rdata <= mem[raddr];
    end

endmodule

// ==== source/uart_regs.sv ====
`timescale 1ns/10ps

module uart_regs (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  awvalid,
    input  loader_pkg::axi_addr_t awaddr,
    output logic                  awready,
    input  logic                  wvalid,
    input  loader_pkg::axi_data_t wdata,
    input  loader_pkg::axi_strb_t wstrb,
    output logic                  wready,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic                  arvalid,
    input  loader_pkg::axi_addr_t araddr,
    output logic                  arready,
    output logic                  rvalid,
    output loader_pkg::axi_data_t rdata,
    input  logic                  rready,

    input  logic                  rx_req,
    input  loader_pkg::byte_t     rx_data,
    output logic                  rx_ack,
    output logic                  tx_req,
    output loader_pkg::byte_t     tx_data,
    input  logic                  tx_ack
);

    logic wr_accept, wr_take, to_tx;
    logic ar_accept, ar_take, rd_pend;

    // A write is taken only when the previous transmit handshake has fully closed
    assign wr_accept = awvalid && wvalid && !awready && !bvalid && !tx_req && !tx_ack;
    assign wr_take   = awvalid && awready;
    assign to_tx     = (awaddr == loader_pkg::UART_ADDR) && wstrb[0];

    assign ar_accept = arvalid && !arready && !rd_pend && !rvalid;
    assign ar_take   = arvalid && arready;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            tx_req  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_pend <= 1'b0;
            rx_ack  <= 1'b0;
        end else begin
            awready <= wr_accept;
            wready  <= wr_accept;
            if (wr_take) begin
                if (to_tx) tx_req <= 1'b1;
                else bvalid <= 1'b1;
            end
            if (tx_req && tx_ack) begin
                tx_req <= 1'b0;
                bvalid <= 1'b1;   // Response waits for the host to take the byte
            end
            if (bvalid && bready) bvalid <= 1'b0;

            arready <= ar_accept;
            if (ar_take) begin
                if (araddr == loader_pkg::UART_ADDR) rd_pend <= 1'b1;
                else rvalid <= 1'b1;
            end
            if (rd_pend && rx_req && !rx_ack) begin
                rd_pend <= 1'b0;
                rx_ack  <= 1'b1;
                rvalid  <= 1'b1;
            end
            if (rx_ack && !rx_req) rx_ack <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take && to_tx) tx_data <= wdata[7:0];
        if (ar_take) rdata <= '0;
        else if (rd_pend && rx_req && !rx_ack) rdata <= loader_pkg::axi_data_t'(rx_data);
    end

endmodule

// ==== verif/tb_loader_top.sv ====
`timescale 1ns/10ps

module tb_loader_top;

    localparam int RAM_DEPTH      = 64;
    localparam int RUNS           = 23;
    localparam int TIMEOUT_CYCLES = RUNS * (RAM_DEPTH * 40 + 200);

    logic              clk;
    logic              rst;
    logic              rx_req;
    loader_pkg::byte_t rx_data;
    logic              rx_ack;
    logic              tx_req;
    loader_pkg::byte_t tx_data;
    logic              tx_ack;
    logic              busy;

    int                seed        = 32'h36f21a83;
    int                errors      = 0;
    int                checks      = 0;
    int                tx_count    = 0;
    int                busy_cycles = 0;
    int                runs_done   = 0;
    loader_pkg::byte_t prog [RAM_DEPTH];
    loader_pkg::byte_t exp_q [$];
    loader_pkg::byte_t act_q [$];

    loader_top #(.RAM_DEPTH(RAM_DEPTH)) i_dut (
        .clk(clk), .rst(rst),
        .rx_req(rx_req), .rx_data(rx_data), .rx_ack(rx_ack),
        .tx_req(tx_req), .tx_data(tx_data), .tx_ack(tx_ack),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (busy) busy_cycles <= busy_cycles + 1;
    end

    // Expected accumulator after running n program bytes on the seed
    function automatic loader_pkg::byte_t model_run(input loader_pkg::byte_t sd,
                                                    input loader_pkg::byte_t p [RAM_DEPTH],
                                                    input int n);
        loader_pkg::byte_t acc;
        logic [15:0]       sh;
        int                i;
        acc = sd;
        for (i = 0; i < n; i++) begin
            case (p[i][7:6])
                loader_pkg::OP_ADD: acc = acc + {2'b00, p[i][5:0]};
                loader_pkg::OP_XOR: acc = acc ^ {2'b00, p[i][5:0]};
                loader_pkg::OP_SUB: acc = acc - {2'b00, p[i][5:0]};
                default: begin
                    sh  = {8'h00, acc} << p[i][2:0];
                    acc = sh[7:0] | sh[15:8];   // Bits shifted out wrap to the bottom
                end
            endcase
        end
        return acc;
    endfunction

    // One four-phase transfer on the host receive stream
    task automatic send_byte(input loader_pkg::byte_t b);
        int unsigned d;
        d = $unsigned($random(seed)) % 4;
        repeat (d) @(posedge clk);
        rx_req  <= 1'b1;
        rx_data <= b;
        @(posedge clk);
        while (!rx_ack) @(posedge clk);
        d = $unsigned($random(seed)) % 4;
        repeat (d) @(posedge clk);
        rx_req <= 1'b0;
        @(posedge clk);
        while (rx_ack) @(posedge clk);
    endtask

    task automatic wait_tx(input int n);
        while (tx_count < n) @(posedge clk);
    endtask

    task automatic do_run(input int n, input loader_pkg::byte_t sd);
        int base;
        int busy_start;
        int i;
        base = 3 * runs_done;
        wait_tx(base + 1);
        exp_q.push_back(loader_pkg::CMD_DATA);
        exp_q.push_back(model_run(sd, prog, n));
        exp_q.push_back(loader_pkg::CMD_PROGRAM);
        busy_start = busy_cycles;
        send_byte(loader_pkg::byte_t'(n));
        for (i = 0; i < n; i++) begin
            send_byte(prog[i]);
        end
        wait_tx(base + 2);
        checks++;
        if (busy_cycles != busy_start) begin
            $display("Fail at %0t: busy high before the seed of run %0d", $time, runs_done);
            errors++;
        end
        busy_start = busy_cycles;
        send_byte(sd);
        wait_tx(base + 3);
        checks++;
        if (busy_cycles == busy_start) begin
            $display("Fail at %0t: busy never rose in run %0d", $time, runs_done);
            errors++;
        end
        runs_done++;
    endtask

    // Host side of the transmit stream
    initial begin : tx_host
        int unsigned d;
        tx_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (tx_req && !tx_ack) begin
                d = $unsigned($random(seed)) % 6;
                repeat (d) @(posedge clk);
                act_q.push_back(tx_data);
                tx_count++;
                tx_ack <= 1'b1;
                while (tx_req) @(posedge clk);
                tx_ack <= 1'b0;
            end
        end
    end

    initial begin : compare_bytes
        loader_pkg::byte_t act;
        loader_pkg::byte_t expv;
        int                idx;
        idx = 0;
        forever begin
            @(posedge clk);
            while (act_q.size() != 0) begin
                act = act_q.pop_front();
                checks++;
                if (exp_q.size() == 0) begin
                    $display("Byte %02h was transmitted at %0t while none was expected",
                             act, $time);
                    errors++;
                end else begin
                    expv = exp_q.pop_front();
                    if (act != expv) begin
                        $display("Fail at %0t: byte %0d expected %02h, got %02h",
                                 $time, idx, expv, act);
                        errors++;
                    end
                end
                if (idx == 0 && busy_cycles != 0) begin
                    $display("Fail at %0t: busy was high before the first prompt", $time);
                    errors++;
                end
                idx++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        loader_pkg::byte_t sd;
        int                n;
        int                i;
        int                r;
        rst     = 1'b1;
        rx_req  = 1'b0;
        rx_data = '0;
        exp_q.push_back(loader_pkg::CMD_PROGRAM);
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        prog[0] = 8'h05;    // add 5
        prog[1] = 8'h5A;    // xor 0x1A
        prog[2] = 8'h83;    // sub 3
        prog[3] = 8'hC3;    // rol 3
        prog[4] = 8'h3F;
        prog[5] = 8'hFE;    // Rotate amount is 6
        do_run(6, 8'h7C);
        do_run(0, 8'hD3);

        for (i = 0; i < RAM_DEPTH; i++) begin
            prog[i] = loader_pkg::byte_t'($random(seed));
        end
        do_run(RAM_DEPTH, 8'h3E);

        for (r = 0; r < 20; r++) begin
            n = $unsigned($random(seed)) % (RAM_DEPTH + 1);
            for (i = 0; i < n; i++) begin
                prog[i] = loader_pkg::byte_t'($random(seed));
            end
            sd = loader_pkg::byte_t'($random(seed));
            do_run(n, sd);
        end

        wait_tx(3 * RUNS + 1);
        repeat (4) @(posedge clk);
        checks++;
        if (busy) begin
            $display("Fail at %0t: busy still high after the last run", $time);
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
